/* src/kickerPkg.sv */
package kickerPkg;

	// ========================================================================
	// defaults for the top level parameters
	// ========================================================================

	// cycle counter width, 18 bits covers over 3 ms at 80 MHz
	localparam int DEFAULT_COUNT_WIDTH = 18;
	// 2^5 = 32 samples in the moving average
	localparam int DEFAULT_AVG_LOG2 = 5;
	// phase saturates here, pulser counts as silent
	localparam int DEFAULT_MAX_PERIOD = 4000;
	// cycles the kicker stays on after a fault
	localparam int DEFAULT_FAULT_HOLD = 500;

	// ========================================================================
	// shared types
	// ========================================================================

	// cycle count for widths, phases and the mean
	typedef logic [DEFAULT_COUNT_WIDTH-1:0] countT;

	// number of pulser periods for kicker on / off
	typedef logic [6:0] ratioT;

	// one complete period of a pulse train
	// high samples from the rising edge, then low samples up to the next one
	typedef struct packed {
		countT highCycles;
		countT lowCycles;
	} periodRecordT;

	// kicker gate states
	// faultHold keeps the kicker on while it ramps down safely
	typedef enum logic [1:0] {
		idle,
		kickOff,
		kickOn,
		faultHold
	} kickStateT;

endpackage

/* src/pulseTrainTimer.sv */
`timescale 1ns/1ps

module pulseTrainTimer #(
	parameter int COUNT_WIDTH = kickerPkg::DEFAULT_COUNT_WIDTH,
	parameter int MAX_PERIOD = kickerPkg::DEFAULT_MAX_PERIOD
)(
	input logic CLOCK_80MHZ,
	input logic resetButton,
	input logic trainIn,
	output kickerPkg::countT phase,
	output logic rise,
	output logic timedOut,
	output logic recordValid,
	output kickerPkg::periodRecordT record
);

	// arming sequence: low, rise, high, low, then every rise closes a period
	typedef enum logic [1:0] {
		waitLow,
		waitRise,
		firstPeriod,
		armed
	} armStateT;

	// saturation point of the phase counter
	localparam logic [COUNT_WIDTH-1:0] PHASE_MAX = COUNT_WIDTH'(MAX_PERIOD);

	armStateT armState;
	logic prevIn;
	logic riseDetect;
	kickerPkg::countT highCount;
	kickerPkg::countT lowCount;

	// first high sample after a low one, never before the first low
	assign riseDetect = trainIn && !prevIn && (armState != waitLow);

	// ========================================================================
	// arming FSM and edge strobes
	// ========================================================================
	always_ff @(posedge CLOCK_80MHZ)
	begin
		if (resetButton)
		begin
			armState <= waitLow;
			prevIn <= 1'b0;
			rise <= 1'b0;
			recordValid <= 1'b0;
		end
		else
		begin
			prevIn <= trainIn;
			rise <= riseDetect;
			// only a fully seen period is reported
			recordValid <= riseDetect && (armState == armed);
			case (armState)
				waitLow:
					if (!trainIn)
						armState <= waitRise;
				waitRise:
					if (riseDetect)
						armState <= firstPeriod;
				firstPeriod:
					// high part seen, low now closes the first period
					if (!trainIn)
						armState <= armed;
				default:
					armState <= armed;
			endcase
		end
	end

	// ========================================================================
	// phase since last rising edge
	// ========================================================================
	always_ff @(posedge CLOCK_80MHZ)
	begin
		// no edge seen yet counts as silent
		if (resetButton)
			phase <= PHASE_MAX;
		else if (riseDetect)
			phase <= '0;
		else if (phase != PHASE_MAX)
			phase <= phase + 1'b1;
	end

	assign timedOut = (phase == PHASE_MAX);

	// ========================================================================
	// high and low width counters
	// ========================================================================
	always_ff @(posedge CLOCK_80MHZ)
	begin
		if (riseDetect)
		begin
			// hand over the period that just ended
			record.highCycles <= highCount;
			record.lowCycles <= lowCount;
			// the rising sample itself is the first high one
			highCount <= kickerPkg::countT'(1);
			lowCount <= '0;
		end
		else if (trainIn)
		begin
			if (highCount != '1)
				highCount <= highCount + 1'b1;
		end
		else if (lowCount != '1)
			lowCount <= lowCount + 1'b1;
	end

endmodule

/* src/offsetAverager.sv */
`timescale 1ns/1ps

module offsetAverager #(
	parameter int COUNT_WIDTH = kickerPkg::DEFAULT_COUNT_WIDTH,
	parameter int AVG_LOG2 = kickerPkg::DEFAULT_AVG_LOG2
)(
	input logic CLOCK_80MHZ,
	input logic resetButton,
	input logic sample,
	input kickerPkg::countT phase,
	input logic clear,
	output kickerPkg::countT meanOffset,
	output logic meanValid
);

	// ring depth, power of two so the mean is a plain shift
	localparam int DEPTH = 1 << AVG_LOG2;
	// sum of DEPTH phases never overflows this
	localparam int SUM_WIDTH = COUNT_WIDTH + AVG_LOG2;
	localparam logic [AVG_LOG2:0] FILL_FULL = (AVG_LOG2 + 1)'(DEPTH);
	localparam logic [AVG_LOG2:0] FILL_LAST = (AVG_LOG2 + 1)'(DEPTH - 1);

	// ring of sampled pulser phases
	kickerPkg::countT phaseRing [DEPTH];

	logic [AVG_LOG2-1:0] writePtr;
	logic [AVG_LOG2:0] fillCount;
	logic [SUM_WIDTH-1:0] phaseSum;
	logic [SUM_WIDTH-1:0] sumNext;
	logic [SUM_WIDTH-1:0] oldestPhase;
	logic ringFull;

	assign ringFull = (fillCount == FILL_FULL);

	// ========================================================================
	// running sum
	// ========================================================================

	// slot under writePtr holds the oldest sample once the ring is full
	// before that its contents are stale and must not be subtracted
	assign oldestPhase = ringFull ? SUM_WIDTH'(phaseRing[writePtr]) : '0;
	assign sumNext = phaseSum + SUM_WIDTH'(phase) - oldestPhase;

	// ring storage
	always_ff @(posedge CLOCK_80MHZ)
	begin
		if (sample && !clear)
			phaseRing[writePtr] <= phase;
	end

	// pointer, fill level, sum, valid flag
	always_ff @(posedge CLOCK_80MHZ)
	begin
		if (resetButton || clear)
		begin
			writePtr <= '0;
			fillCount <= '0;
			phaseSum <= '0;
			meanValid <= 1'b0;
		end
		else if (sample)
		begin
			// wraps naturally at DEPTH
			writePtr <= writePtr + 1'b1;
			phaseSum <= sumNext;
			if (!ringFull)
				fillCount <= fillCount + 1'b1;
			// valid together with the update holding the last slot
			if (fillCount == FILL_LAST)
				meanValid <= 1'b1;
		end
	end

	// ========================================================================
	// mean output
	// ========================================================================
	always_ff @(posedge CLOCK_80MHZ)
	begin
		// floor of sum / DEPTH
		if (sample && !clear)
			meanOffset <= sumNext[SUM_WIDTH-1:AVG_LOG2];
	end

endmodule

/* src/kickerGate.sv */
`timescale 1ns/1ps

module kickerGate #(
	parameter int COUNT_WIDTH = kickerPkg::DEFAULT_COUNT_WIDTH,
	parameter int FAULT_HOLD = kickerPkg::DEFAULT_FAULT_HOLD
)(
	input logic CLOCK_80MHZ,
	input logic resetButton,
	input kickerPkg::countT phase,
	input kickerPkg::countT meanOffset,
	input logic meanValid,
	input logic timedOut,
	input kickerPkg::ratioT onRatio,
	input kickerPkg::ratioT offRatio,
	output logic kick,
	output logic fault,
	output logic clear
);

	// last cycle of the fault hold
	localparam logic [COUNT_WIDTH-1:0] HOLD_LAST = COUNT_WIDTH'(FAULT_HOLD - 1);

	kickerPkg::kickStateT state;
	kickerPkg::ratioT matchCount;
	logic [COUNT_WIDTH-1:0] holdCount;
	logic [7:0] matchNext;
	logic match;
	logic offDone;
	logic onDone;

	// pulser at the mean beam phase, and pulser still alive
	assign match = (phase == meanOffset) && !timedOut;

	// one wider so a count of 127 cannot wrap
	assign matchNext = {1'b0, matchCount} + 8'd1;
	// a ratio of 0 acts like 1
	assign offDone = (matchNext >= {1'b0, offRatio});
	assign onDone = (matchNext >= {1'b0, onRatio});

	// ========================================================================
	// gate FSM
	// ========================================================================
	always_ff @(posedge CLOCK_80MHZ)
	begin
		if (resetButton)
		begin
			state <= kickerPkg::idle;
			matchCount <= '0;
			holdCount <= '0;
			fault <= 1'b0;
			clear <= 1'b0;
		end
		else
		begin
			// strobes default low
			fault <= 1'b0;
			clear <= 1'b0;
			case (state)
				kickerPkg::idle:
				begin
					matchCount <= '0;
					// meanValid is still stale while our own clear is out
					if (meanValid && !clear)
						state <= kickerPkg::kickOff;
				end
				kickerPkg::kickOff:
				begin
					if (timedOut)
					begin
						// kicker already off, just restart
						state <= kickerPkg::idle;
						fault <= 1'b1;
						clear <= 1'b1;
					end
					else if (match)
					begin
						if (offDone)
						begin
							state <= kickerPkg::kickOn;
							matchCount <= '0;
						end
						else
							matchCount <= matchNext[6:0];
					end
				end
				kickerPkg::kickOn:
				begin
					if (timedOut)
					begin
						// pulser lost while on, keep kicker up for the hold time
						state <= kickerPkg::faultHold;
						holdCount <= '0;
						fault <= 1'b1;
						clear <= 1'b1;
					end
					else if (match)
					begin
						if (onDone)
						begin
							state <= kickerPkg::kickOff;
							matchCount <= '0;
						end
						else
							matchCount <= matchNext[6:0];
					end
				end
				default:
				begin
					// faultHold, FAULT_HOLD cycles then back to idle
					if (holdCount == HOLD_LAST)
						state <= kickerPkg::idle;
					else
						holdCount <= holdCount + 1'b1;
				end
			endcase
		end
	end

	// kicker follows the state directly
	assign kick = (state == kickerPkg::kickOn) || (state == kickerPkg::faultHold);

endmodule

/* src/kickerController.sv */
`timescale 1ns/1ps

module kickerController #(
	parameter int COUNT_WIDTH = kickerPkg::DEFAULT_COUNT_WIDTH,
	parameter int AVG_LOG2 = kickerPkg::DEFAULT_AVG_LOG2,
	parameter int MAX_PERIOD = kickerPkg::DEFAULT_MAX_PERIOD,
	parameter int FAULT_HOLD = kickerPkg::DEFAULT_FAULT_HOLD
)(
	input logic CLOCK_80MHZ,
	input logic resetButton,
	input logic pulserIn,
	input logic beamIn,
	input kickerPkg::ratioT onRatio,
	input kickerPkg::ratioT offRatio,
	output kickerPkg::periodRecordT beamRecord,
	output logic beamRecordValid,
	output kickerPkg::countT meanOffset,
	output logic meanValid,
	output logic kick,
	output logic fault
);

	kickerPkg::countT pulserPhase;
	logic pulserTimedOut;
	logic beamRise;
	logic clearAverage;

	// ========================================================================
	// pulse train analysis
	// ========================================================================

	// pulser reference, only its phase and timeout are needed
	pulseTrainTimer #(
		.COUNT_WIDTH(COUNT_WIDTH),
		.MAX_PERIOD(MAX_PERIOD)
	) pulserTimer (
		.CLOCK_80MHZ(CLOCK_80MHZ),
		.resetButton(resetButton),
		.trainIn(pulserIn),
		.phase(pulserPhase),
		.rise(),
		.timedOut(pulserTimedOut),
		.recordValid(),
		.record()
	);

	// beam detector, rise strobes the averager, record goes out
	pulseTrainTimer #(
		.COUNT_WIDTH(COUNT_WIDTH),
		.MAX_PERIOD(MAX_PERIOD)
	) beamTimer (
		.CLOCK_80MHZ(CLOCK_80MHZ),
		.resetButton(resetButton),
		.trainIn(beamIn),
		.phase(),
		.rise(beamRise),
		.timedOut(),
		.recordValid(beamRecordValid),
		.record(beamRecord)
	);

	// ========================================================================
	// offset averaging
	// ========================================================================
	offsetAverager #(
		.COUNT_WIDTH(COUNT_WIDTH),
		.AVG_LOG2(AVG_LOG2)
	) averager (
		.CLOCK_80MHZ(CLOCK_80MHZ),
		.resetButton(resetButton),
		.sample(beamRise),
		.phase(pulserPhase),
		.clear(clearAverage),
		.meanOffset(meanOffset),
		.meanValid(meanValid)
	);

	// ========================================================================
	// trigger FSM
	// ========================================================================
	kickerGate #(
		.COUNT_WIDTH(COUNT_WIDTH),
		.FAULT_HOLD(FAULT_HOLD)
	) gate (
		.CLOCK_80MHZ(CLOCK_80MHZ),
		.resetButton(resetButton),
		.phase(pulserPhase),
		.meanOffset(meanOffset),
		.meanValid(meanValid),
		.timedOut(pulserTimedOut),
		.onRatio(onRatio),
		.offRatio(offRatio),
		.kick(kick),
		.fault(fault),
		.clear(clearAverage)
	);

endmodule

/* tb/kickerModel.svh */
`ifndef KICKER_MODEL_SVH
`define KICKER_MODEL_SVH

// ============================================================================
// cycle model of the kicker controller
// ============================================================================

// index 0 is the pulser train, index 1 the beam train
// arming stages of a train
localparam int STAGE_WAIT_LOW = 0;
localparam int STAGE_WAIT_RISE = 1;
localparam int STAGE_FIRST = 2;
localparam int STAGE_ARMED = 3;

bit mPrev [2];
int mArm [2];
int unsigned mPhase [2];
int unsigned mHigh [2];
int unsigned mLow [2];
int unsigned mRecHigh [2];
int unsigned mRecLow [2];
bit mRise [2];
bit mRecValid [2];

// last sampled pulser phases, oldest first
int unsigned phaseHistory [$];
int unsigned mMean;
bit mMeanValid;

kickerPkg::kickStateT mState;
int mMatches;
int mHold;
bit mFault;
bit mClear;

// kicker is on while kicking or ramping down
function automatic bit expectedKick();
	return (mState == kickerPkg::kickOn) || (mState == kickerPkg::faultHold);
endfunction

task automatic resetModel();
	for (int i = 0; i < 2; i++)
	begin
		mPrev[i] = 1'b0;
		mArm[i] = STAGE_WAIT_LOW;
		// silent until the first edge
		mPhase[i] = MAX_PERIOD;
		mHigh[i] = 0;
		mLow[i] = 0;
		mRecHigh[i] = 0;
		mRecLow[i] = 0;
		mRise[i] = 1'b0;
		mRecValid[i] = 1'b0;
	end
	phaseHistory.delete();
	mMean = 0;
	mMeanValid = 1'b0;
	mState = kickerPkg::idle;
	mMatches = 0;
	mHold = 0;
	mFault = 1'b0;
	mClear = 1'b0;
endtask

// one sample of one train
task automatic advanceTrain(input int idx, input bit level);
	bit edgeSeen;
	// high after low, only once a low was seen
	edgeSeen = level && !mPrev[idx] && (mArm[idx] != STAGE_WAIT_LOW);
	mRise[idx] = edgeSeen;
	mRecValid[idx] = edgeSeen && (mArm[idx] == STAGE_ARMED);
	if (edgeSeen)
	begin
		mRecHigh[idx] = mHigh[idx];
		mRecLow[idx] = mLow[idx];
		mHigh[idx] = 1;
		mLow[idx] = 0;
		mPhase[idx] = 0;
	end
	else
	begin
		if (level)
			mHigh[idx]++;
		else
			mLow[idx]++;
		if (mPhase[idx] < MAX_PERIOD)
			mPhase[idx]++;
	end
	case (mArm[idx])
		STAGE_WAIT_LOW:
			if (!level)
				mArm[idx] = STAGE_WAIT_RISE;
		STAGE_WAIT_RISE:
			if (edgeSeen)
				mArm[idx] = STAGE_FIRST;
		STAGE_FIRST:
			if (!level)
				mArm[idx] = STAGE_ARMED;
		default:
			mArm[idx] = STAGE_ARMED;
	endcase
	mPrev[idx] = level;
endtask

// moving average over the last AVG_DEPTH phases
task automatic updateAverager(input bit sampleNow, input int unsigned phaseNow, input bit clearNow);
	int unsigned total;
	if (clearNow)
	begin
		phaseHistory.delete();
		mMeanValid = 1'b0;
	end
	else if (sampleNow)
	begin
		phaseHistory.push_back(phaseNow);
		if (phaseHistory.size() > AVG_DEPTH)
			void'(phaseHistory.pop_front());
		total = 0;
		foreach (phaseHistory[i])
			total += phaseHistory[i];
		// floor mean, missing samples count as zero
		mMean = total / AVG_DEPTH;
		mMeanValid = (phaseHistory.size() == AVG_DEPTH);
	end
endtask

task automatic nextGateState(input int unsigned phaseNow, input int unsigned meanNow,
	input bit meanOk, input bit silent, input bit clearOut);
	bit match;
	match = (phaseNow == meanNow) && !silent;
	mFault = 1'b0;
	mClear = 1'b0;
	case (mState)
		kickerPkg::idle:
		begin
			mMatches = 0;
			// wait until our own clear has landed
			if (meanOk && !clearOut)
				mState = kickerPkg::kickOff;
		end
		kickerPkg::kickOff:
		begin
			if (silent)
			begin
				mState = kickerPkg::idle;
				mFault = 1'b1;
				mClear = 1'b1;
			end
			else if (match)
			begin
				mMatches++;
				if (mMatches >= offRatio)
				begin
					mState = kickerPkg::kickOn;
					mMatches = 0;
				end
			end
		end
		kickerPkg::kickOn:
		begin
			if (silent)
			begin
				mState = kickerPkg::faultHold;
				mHold = 0;
				mFault = 1'b1;
				mClear = 1'b1;
			end
			else if (match)
			begin
				mMatches++;
				if (mMatches >= onRatio)
				begin
					mState = kickerPkg::kickOff;
					mMatches = 0;
				end
			end
		end
		default:
		begin
			if (mHold == FAULT_HOLD - 1)
				mState = kickerPkg::idle;
			else
				mHold++;
		end
	endcase
endtask

// one rising clock edge with the given input levels
task automatic stepModel(input bit pulserLevel, input bit beamLevel);
	int unsigned phaseNow;
	int unsigned meanNow;
	bit meanOk;
	bit silent;
	bit beamRise;
	bit clearOut;
	// every block sees the registered values from before the edge
	phaseNow = mPhase[0];
	meanNow = mMean;
	meanOk = mMeanValid;
	silent = (mPhase[0] == MAX_PERIOD);
	beamRise = mRise[1];
	clearOut = mClear;
	nextGateState(phaseNow, meanNow, meanOk, silent, clearOut);
	updateAverager(beamRise, phaseNow, clearOut);
	advanceTrain(0, pulserLevel);
	advanceTrain(1, beamLevel);
endtask

`endif

/* tb/kickerControllerTb.sv */
`timescale 1ns/1ps

module kickerControllerTb;

	localparam int COUNT_WIDTH = kickerPkg::DEFAULT_COUNT_WIDTH;
	localparam int AVG_LOG2 = kickerPkg::DEFAULT_AVG_LOG2;
	localparam int AVG_DEPTH = 1 << AVG_LOG2;
	// short timeout and fault hold
	localparam int MAX_PERIOD = 400;
	localparam int FAULT_HOLD = 50;
	localparam int SEED = 61204;

	// test lengths in pulser periods
	localparam int ARM_PERIODS = 4;
	localparam int RECORD_PERIODS = 36;
	localparam int MEAN_PERIODS = 10;
	localparam int RATIO_PERIODS = 120;
	localparam int KICK_WAIT_PERIODS = 20;
	localparam int WARMUP_PERIODS = 2;
	localparam int REFILL_PERIODS = 60;
	localparam int TOTAL_PERIODS = ARM_PERIODS + RECORD_PERIODS + MEAN_PERIODS
		+ RATIO_PERIODS + KICK_WAIT_PERIODS + WARMUP_PERIODS + REFILL_PERIODS;
	// pulser stopped windows
	localparam int STOP_ON_CYCLES = MAX_PERIOD + FAULT_HOLD + 20;
	localparam int STOP_OFF_CYCLES = MAX_PERIOD + 40;
	// no pulser period comes close to MAX_PERIOD cycles
	localparam longint WATCHDOG_NS = 64'd20 * (TOTAL_PERIODS * MAX_PERIOD
		+ STOP_ON_CYCLES + STOP_OFF_CYCLES + 2000);

	logic CLOCK_80MHZ;
	logic resetButton;
	logic pulserIn;
	logic beamIn;
	kickerPkg::ratioT onRatio;
	kickerPkg::ratioT offRatio;
	kickerPkg::periodRecordT beamRecord;
	logic beamRecordValid;
	kickerPkg::countT meanOffset;
	logic meanValid;
	logic kick;
	logic fault;

	int errors;
	int checks;
	int tests;

	// stimulus generator state for the pulser period and beam lag
	int gPeriod;
	int gHigh;
	int gBase;
	int gLag;
	int gWidth;
	int gPos;

	`include "kickerModel.svh"

	kickerController #(
		.COUNT_WIDTH(COUNT_WIDTH),
		.AVG_LOG2(AVG_LOG2),
		.MAX_PERIOD(MAX_PERIOD),
		.FAULT_HOLD(FAULT_HOLD)
	) UUT (
		.CLOCK_80MHZ(CLOCK_80MHZ),
		.resetButton(resetButton),
		.pulserIn(pulserIn),
		.beamIn(beamIn),
		.onRatio(onRatio),
		.offRatio(offRatio),
		.beamRecord(beamRecord),
		.beamRecordValid(beamRecordValid),
		.meanOffset(meanOffset),
		.meanValid(meanValid),
		.kick(kick),
		.fault(fault)
	);

	// ========================================================================
	// clock and watchdog
	// ========================================================================
	initial
	begin
		CLOCK_80MHZ = 1'b0;
		forever #10 CLOCK_80MHZ = ~CLOCK_80MHZ;
	end

	initial
	begin
		#(WATCHDOG_NS);
		$display("watchdog expired before the test sequence completed");
		$display("Test FAILED");
		$finish;
	end

	// ========================================================================
	// helpers
	// ========================================================================
	task automatic reportMismatch(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		$display("Mismatch %s: expected %h, got %h", name, expected, actual);
		errors++;
	endtask

	task automatic reportFailure(input string text);
		$display("%s", text);
		errors++;
	endtask

	task automatic reportTest(input string name, input int startErrors);
		tests++;
		$display("test %0d %s finished with %0d errors", tests, name, errors - startErrors);
	endtask

	// compare every DUT output with the model
	task automatic checkOutputs();
		checks++;
		if (kick !== expectedKick())
			reportMismatch("kick", expectedKick(), kick);
		if (fault !== mFault)
			reportMismatch("fault", mFault, fault);
		if (meanValid !== mMeanValid)
			reportMismatch("meanValid", mMeanValid, meanValid);
		if (beamRecordValid !== mRecValid[1])
			reportMismatch("beamRecordValid", mRecValid[1], beamRecordValid);
		if (mRecValid[1])
		begin
			if (beamRecord.highCycles !== kickerPkg::countT'(mRecHigh[1]))
				reportMismatch("beamRecord.highCycles", mRecHigh[1], beamRecord.highCycles);
			if (beamRecord.lowCycles !== kickerPkg::countT'(mRecLow[1]))
				reportMismatch("beamRecord.lowCycles", mRecLow[1], beamRecord.lowCycles);
		end
		if (mMeanValid && (meanOffset !== kickerPkg::countT'(mMean)))
			reportMismatch("meanOffset", mMean, meanOffset);
	endtask

	// drive one cycle at the falling edge, compare at the next one
	task automatic runCycle(input bit pulserOn, input bit beamOn);
		bit pLevel;
		bit bLevel;
		// new beam lag and width every pulser period
		if (gPos == 0)
		begin
			gLag = gBase + $urandom_range(0, 3);
			gWidth = $urandom_range(2, 6);
		end
		pLevel = pulserOn && (gPos < gHigh);
		bLevel = beamOn && (gPos >= gLag) && (gPos < gLag + gWidth);
		gPos = (gPos + 1) % gPeriod;
		pulserIn = pLevel;
		beamIn = bLevel;
		stepModel(pLevel, bLevel);
		@(negedge CLOCK_80MHZ);
		checkOutputs();
	endtask

	// ========================================================================
	// test sequence
	// ========================================================================
	initial
	begin
		int startErrors;
		int cycles;
		int records;
		int switches;
		int faults;
		int kickCycles;
		bit found;
		logic lastKick;

		void'($urandom(SEED));
		resetButton = 1'b1;
		pulserIn = 1'b0;
		beamIn = 1'b0;
		onRatio = 7'd1;
		offRatio = 7'd1;
		errors = 0;
		checks = 0;
		tests = 0;
		// fixed pulser period with the beam a few cycles after gBase
		gPeriod = $urandom_range(40, 80);
		gHigh = $urandom_range(5, 15);
		gBase = $urandom_range(2, gPeriod - 12);
		gPos = 0;
		repeat (16) @(posedge CLOCK_80MHZ);
		@(negedge CLOCK_80MHZ);
		resetButton = 1'b0;
		resetModel();

		// quiet outputs up to the first full beam period
		startErrors = errors;
		cycles = 0;
		while (!beamRecordValid && (cycles < ARM_PERIODS * gPeriod))
		begin
			runCycle(1'b1, 1'b1);
			cycles++;
			if (kick || fault || meanValid)
				reportFailure("kick, fault or meanValid rose before the first beam period");
		end
		if (!beamRecordValid)
			reportFailure("no beam record after the first beam periods");
		reportTest("arming", startErrors);

		// beam period records
		startErrors = errors;
		records = 0;
		repeat (RECORD_PERIODS * gPeriod)
		begin
			runCycle(1'b1, 1'b1);
			if (beamRecordValid)
				records++;
		end
		if (records < RECORD_PERIODS - 2)
			reportFailure($sformatf("only %0d beam records in %0d periods", records,
				RECORD_PERIODS));
		reportTest("records", startErrors);

		// moving average is full by now
		startErrors = errors;
		repeat (MEAN_PERIODS * gPeriod)
			runCycle(1'b1, 1'b1);
		if (!meanValid)
			reportFailure("meanValid never rose after 32 beam rising edges");
		reportTest("mean", startErrors);

		// on/off ratio sequence
		startErrors = errors;
		onRatio = $urandom_range(1, 7);
		offRatio = $urandom_range(1, 7);
		switches = 0;
		lastKick = kick;
		repeat (RATIO_PERIODS * gPeriod)
		begin
			runCycle(1'b1, 1'b1);
			if (kick !== lastKick)
				switches++;
			lastKick = kick;
		end
		if (switches < 2)
			reportFailure("kick did not toggle with the on and off ratios");
		reportTest("ratio", startErrors);

		// stop the pulser while kicking and past the mean phase
		startErrors = errors;
		found = 1'b0;
		cycles = 0;
		while (!found && (cycles < KICK_WAIT_PERIODS * gPeriod))
		begin
			runCycle(1'b1, 1'b1);
			cycles++;
			found = (mState == kickerPkg::kickOn) && (mPhase[0] > mMean)
				&& (mPhase[0] < MAX_PERIOD);
		end
		if (!found)
			reportFailure("kicker never turned on before the pulser stop");
		faults = 0;
		kickCycles = 0;
		repeat (STOP_ON_CYCLES)
		begin
			runCycle(1'b0, 1'b0);
			if (fault)
				faults++;
			if ((faults > 0) && kick)
				kickCycles++;
		end
		if (faults != 1)
			reportFailure($sformatf("%0d fault pulses with the kicker on, one expected", faults));
		if (kickCycles != FAULT_HOLD)
			reportMismatch("kick hold cycles", FAULT_HOLD, kickCycles);
		if (kick || meanValid)
			reportFailure("kick or meanValid still high after the fault hold");
		reportTest("fault while on", startErrors);

		// pulser first so the refill sees real phases
		startErrors = errors;
		repeat (WARMUP_PERIODS * gPeriod)
			runCycle(1'b1, 1'b0);
		found = 1'b0;
		cycles = 0;
		while (!found && (cycles < REFILL_PERIODS * gPeriod))
		begin
			runCycle(1'b1, 1'b1);
			cycles++;
			found = mMeanValid && (mState == kickerPkg::kickOff) && (mPhase[0] > mMean)
				&& (mPhase[0] < MAX_PERIOD);
		end
		if (!found)
			reportFailure("kicker never back in the off state after the refill");
		faults = 0;
		kickCycles = 0;
		repeat (STOP_OFF_CYCLES)
		begin
			runCycle(1'b0, 1'b0);
			if (fault)
				faults++;
			if (kick)
				kickCycles++;
		end
		if (faults != 1)
			reportFailure($sformatf("%0d fault pulses with the kicker off, one expected", faults));
		if (kickCycles != 0)
			reportFailure("kick went high after the pulser stopped in the off state");
		if (meanValid)
			reportFailure("meanValid still high after the fault");
		reportTest("fault while off", startErrors);

		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

/* filelist.f */
+incdir+tb
src/kickerPkg.sv
src/pulseTrainTimer.sv
src/offsetAverager.sv
src/kickerGate.sv
src/kickerController.sv
tb/kickerControllerTb.sv

/* Bender.yml */
package:
  name: kicker_controller

sources:
  - src/kickerPkg.sv
  - src/pulseTrainTimer.sv
  - src/offsetAverager.sv
  - src/kickerGate.sv
  - src/kickerController.sv
  - target: simulation
    include_dirs:
      - tb
    files:
      - tb/kickerControllerTb.sv
